/* verification/decode_patterns.txt */
// pc inst pred_pc mode(4:flush 0:pred_valid) rf1 rf2 fwd_ctl(byte per source) fwd0 fwd1 fwd2
// exp_ctrl(alu_op flags dest reserved) exp_rs_value exp_rt_value exp_real_target exp(4:taken 0:mispredict)
400000 00221821 0 0 11111111 22222222 0 0 0 0 00102030 11111111 22222222 400008 0
400010 00a62023 0 0 55555555 66666666 666565 aaaa0000 bbbb0000 cccc0006 00202040 aaaa0000 cccc0006 400018 0
400020 0109382a 0 0 88888888 99999999 694828 deadbeef deadbeef 99990000 00402070 88888888 99990000 400028 0
400030 000b502b 0 0 0 bbbbbbbb 60 12345678 0 0 008020a0 0 bbbbbbbb 400038 0
400040 01ae6024 0 0 1 2 0 0 0 0 010020c0 1 2 400048 0
400050 02117825 0 0 1 2 0 0 0 0 040020f0 1 2 400058 0
400060 02749026 0 0 1 2 0 0 0 0 08002120 1 2 400068 0
400070 01ae6027 0 0 1 2 0 0 0 0 020020c0 1 2 400078 0
400080 00031140 0 0 0 2 0 0 0 0 10082020 0 2 400088 0
400090 00031042 0 0 0 2 0 0 0 0 20082020 0 2 400098 0
4000a0 000317c3 0 0 0 2 0 0 0 0 40082020 0 2 4000a8 0
4000b0 2485ffff 0 0 1 2 0 0 0 0 00122050 1 2 4000b8 0
4000c0 28850007 0 0 1 2 0 0 0 0 00422050 1 2 4000c8 0
4000d0 2c850007 0 0 1 2 0 0 0 0 00822050 1 2 4000d8 0
4000e0 3085ff00 0 0 1 2 0 0 0 0 01012050 1 2 4000e8 0
4000f0 3485ff00 0 0 1 2 0 0 0 0 04012050 1 2 4000f8 0
400100 3885ff00 0 0 1 2 0 0 0 0 08012050 1 2 400108 0
400110 3c061234 0 0 0 2 0 0 0 0 80022060 0 2 400118 0
400120 8fa70008 0 0 1 2 0 0 0 0 00126070 1 2 400128 0
400130 afa7000c 0 1 1 2 0 0 0 0 00121000 1 2 400138 01
400140 fc000000 400148 1 0 0 0 0 0 0 00002001 0 0 400148 0
400150 10220004 400164 1 5 5 0 0 0 0 00000000 5 5 400164 10
400160 1422fffe 40015c 1 7 7 0 0 0 0 000001f0 7 7 400168 01
400170 04610010 0 0 0 2 63 80000000 0 0 00000000 80000000 2 400178 0
400180 0460fffc 400174 1 ffffffff 0 0 0 0 0 000001f0 ffffffff 0 400174 10
400190 18800008 400198 1 0 0 0 0 0 0 00000000 0 0 4001b4 11
4001a0 1c800008 0 0 0 0 0 0 0 0 00000000 0 0 4001a8 0
4001b0 08100040 400100 1 0 2 0 0 0 0 00000000 0 2 400100 10
4001c0 0c100080 0 0 0 2 0 0 0 0 0014a1f0 0 2 400200 10
4001d0 03e00008 400000 1 11111111 0 7f5f deadbeef 00400300 0 00000000 00400300 0 400300 11
4001e0 00221821 0 10 1 2 0 0 0 0 00102030 1 2 4001e8 0
4001f0 10220004 0 11 5 5 0 0 0 0 00000000 5 5 400204 11

/* all.f */
hdl/decode_pkg.sv
hdl/fetch_latch.sv
hdl/inst_decoder.sv
hdl/branch_resolver.sv
hdl/issue_merge.sv
hdl/decode_stage.sv
verification/decode_checker.sv
verification/decode_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = decode_tb
FILELIST  = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "NO ERRORS"

clean:
	rm -rf obj_dir

/* verification/decode_tb.sv */
`timescale 1ns/1ps

module decode_tb;

    localparam int NUM_VEC    = 32;
    localparam int WORDS      = 15;
    localparam int MAX_CYCLES = NUM_VEC * 8 + 20;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      in_valid;
    logic                      in_ready;
    decode_pkg::fetch_bundle_t in_bundle;
    logic                      out_valid;
    logic                      out_ready;
    decode_pkg::issue_bundle_t out_bundle;
    decode_pkg::reg_addr_t     rf_raddr1;
    decode_pkg::reg_addr_t     rf_raddr2;
    decode_pkg::word_t         rf_rdata1;
    decode_pkg::word_t         rf_rdata2;
    decode_pkg::fwd_src_t      fwd [3];
    logic                      stall;
    logic                      flush;
    logic                      taken;
    decode_pkg::word_t         target;
    logic                      mispredict;

    // expectations for the vector currently in the stage
    decode_pkg::issue_bundle_t exp_bundle;
    logic                      exp_taken;
    logic                      exp_mispredict;
    logic                      loaded;
    logic                      run_done;
    int                        vec_id;
    int                        num_unflushed;
    int                        cycles = 0;
    logic [31:0]               rng = 32'hc3ca;
    logic [31:0]               pat [NUM_VEC*WORDS];
    logic                      seen;

    always #20 clk = ~clk;

    decode_stage #(
        .NUM_FWD (3)
    ) dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_bundle (out_bundle),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .fwd        (fwd),
        .stall      (stall),
        .flush      (flush),
        .taken      (taken),
        .target     (target),
        .mispredict (mispredict)
    );

    decode_checker chk_i (
        .clk            (clk),
        .reset          (reset),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_bundle     (out_bundle),
        .flush          (flush),
        .stall          (stall),
        .taken          (taken),
        .mispredict     (mispredict),
        .target         (target),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2),
        .loaded         (loaded),
        .vec_id         (vec_id),
        .exp_bundle     (exp_bundle),
        .exp_taken      (exp_taken),
        .exp_mispredict (exp_mispredict),
        .run_done       (run_done),
        .num_expected   (num_unflushed)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // random back-pressure, ready about three cycles in four, stall about one in four
    always @(posedge clk) begin
        #2;
        rng = xorshift(rng);
        out_ready = (rng[1:0] != 2'b00);
        stall = (rng[3:2] == 2'b00);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, vector %0d never left the stage", cycles, vec_id);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_vector(input int v);
        int b;
        logic [31:0] fctl;
        logic [31:0] cw;
        b = v * WORDS;
        fctl = pat[b+6];
        cw = pat[b+10];
        in_bundle.pc = pat[b];
        in_bundle.inst = pat[b+1];
        in_bundle.pred_pc = pat[b+2];
        in_bundle.pred_valid = pat[b+3][0];
        flush = pat[b+3][4];
        rf_rdata1 = pat[b+4];
        rf_rdata2 = pat[b+5];
        for (int i = 0; i < 3; i++) begin
            fwd[i].valid = fctl[8*i+6];
            fwd[i].reg_write = fctl[8*i+5];
            fwd[i].rd = fctl[8*i +: 5];
            fwd[i].result = pat[b+7+i];
        end
        exp_bundle.ctrl.alu_op = cw[31:20];
        {exp_bundle.ctrl.src1_is_sa, exp_bundle.ctrl.src1_is_pc,
         exp_bundle.ctrl.src2_is_imm, exp_bundle.ctrl.src2_is_zimm,
         exp_bundle.ctrl.src2_is_8, exp_bundle.ctrl.res_from_mem,
         exp_bundle.ctrl.gr_we, exp_bundle.ctrl.mem_we} = cw[19:12];
        exp_bundle.ctrl.dest = cw[8:4];
        exp_bundle.ctrl.imm = pat[b+1][15:0];
        exp_bundle.ctrl.reserved = cw[0];
        exp_bundle.rs = pat[b+1][25:21];
        exp_bundle.rt = pat[b+1][20:16];
        exp_bundle.rs_value = pat[b+11];
        exp_bundle.rt_value = pat[b+12];
        exp_bundle.pc = pat[b];
        exp_bundle.real_target = pat[b+13];
        exp_bundle.pred_pc = pat[b+2];
        exp_taken = pat[b+14][4];
        exp_mispredict = pat[b+14][0];
        vec_id = v;
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_bundle = '0;
        out_ready = 1'b0;
        rf_rdata1 = '0;
        rf_rdata2 = '0;
        for (int i = 0; i < 3; i++) begin
            fwd[i] = '0;
        end
        stall = 1'b0;
        flush = 1'b0;
        exp_bundle = '0;
        exp_taken = 1'b0;
        exp_mispredict = 1'b0;
        loaded = 1'b0;
        run_done = 1'b0;
        vec_id = 0;
        num_unflushed = 0;
        $readmemh("verification/decode_patterns.txt", pat);
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int v = 0; v < NUM_VEC; v++) begin
            load_vector(v);
            if (!flush) begin
                num_unflushed++;
            end
            in_valid = 1'b1;
            seen = 1'b0;
            while (!seen) begin
                @(negedge clk);
                seen = in_ready;
                @(posedge clk);
            end
            #2;
            in_valid = 1'b0;
            loaded = 1'b1;
            // item leaves by a transfer, or silently when flushed
            seen = 1'b0;
            while (!seen) begin
                @(negedge clk);
                seen = out_ready && !stall && (out_valid || flush);
                @(posedge clk);
            end
            #2;
            loaded = 1'b0;
        end
        run_done = 1'b1;
        @(posedge clk);
        #1;
        $display("errors: %0d", chk_i.errors);
        if (chk_i.errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verification/decode_checker.sv */
`timescale 1ns/1ps

module decode_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      out_valid,
    input logic                      out_ready,
    input decode_pkg::issue_bundle_t out_bundle,
    input logic                      flush,
    input logic                      stall,
    input logic                      taken,
    input logic                      mispredict,
    input decode_pkg::word_t         target,
    input decode_pkg::reg_addr_t     rf_raddr1,
    input decode_pkg::reg_addr_t     rf_raddr2,
    input logic                      loaded,
    input int                        vec_id,
    input decode_pkg::issue_bundle_t exp_bundle,
    input logic                      exp_taken,
    input logic                      exp_mispredict,
    input logic                      run_done,
    input int                        num_expected
);

    int errors = 0;
    int xfers = 0;
    int last_id = -1;
    logic held = 1'b0;
    decode_pkg::issue_bundle_t held_bundle;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail vec %0d %s: expected %h, actual %h", vec_id, name, exp, act);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("vec %0d: %s", vec_id, what);
    endtask

    task automatic compare_bundle();
        check_value("alu_op", 32'(exp_bundle.ctrl.alu_op), 32'(out_bundle.ctrl.alu_op));
        // the eight operand source and write enable bits
        check_value("flags", 32'(exp_bundle.ctrl[29:22]), 32'(out_bundle.ctrl[29:22]));
        check_value("dest", 32'(exp_bundle.ctrl.dest), 32'(out_bundle.ctrl.dest));
        check_value("imm", 32'(exp_bundle.ctrl.imm), 32'(out_bundle.ctrl.imm));
        check_value("reserved", 32'(exp_bundle.ctrl.reserved), 32'(out_bundle.ctrl.reserved));
        check_value("rs", 32'(exp_bundle.rs), 32'(out_bundle.rs));
        check_value("rt", 32'(exp_bundle.rt), 32'(out_bundle.rt));
        check_value("rs_value", exp_bundle.rs_value, out_bundle.rs_value);
        check_value("rt_value", exp_bundle.rt_value, out_bundle.rt_value);
        check_value("pc", exp_bundle.pc, out_bundle.pc);
        check_value("real_target", exp_bundle.real_target, out_bundle.real_target);
        check_value("pred_pc", exp_bundle.pred_pc, out_bundle.pred_pc);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (out_valid && !loaded) begin
                report_problem("out_valid is high with no vector in the stage");
            end
            if (held && out_valid && out_bundle !== held_bundle) begin
                report_problem("out_bundle changed while waiting for out_ready");
            end
            // branch outputs hold for as long as the item sits unstalled
            if (loaded) begin
                check_value("taken", 32'(exp_taken && !stall), 32'(taken));
                check_value("mispredict", 32'(exp_mispredict && !stall), 32'(mispredict));
                check_value("target", exp_bundle.real_target, target);
                check_value("rf_raddr1", 32'(exp_bundle.rs), 32'(rf_raddr1));
                check_value("rf_raddr2", 32'(exp_bundle.rt), 32'(rf_raddr2));
            end
            if (loaded && out_valid && out_ready) begin
                if (flush) begin
                    report_problem("a flushed vector was transferred");
                end else if (vec_id <= last_id) begin
                    report_problem("vector transferred twice or out of order");
                end else begin
                    compare_bundle();
                end
                last_id = vec_id;
                xfers++;
            end
            held = out_valid && !out_ready;
            held_bundle = out_bundle;
            if (run_done && xfers != num_expected) begin
                report_problem($sformatf("only %0d of %0d vectors were transferred",
                                         xfers, num_expected));
            end
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
    parameter int NUM_FWD = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  decode_pkg::fetch_bundle_t in_bundle,
    output logic                      out_valid,
    input  logic                      out_ready,
    output decode_pkg::issue_bundle_t out_bundle,
    output decode_pkg::reg_addr_t     rf_raddr1,
    output decode_pkg::reg_addr_t     rf_raddr2,
    input  decode_pkg::word_t         rf_rdata1,
    input  decode_pkg::word_t         rf_rdata2,
    input  decode_pkg::fwd_src_t      fwd [NUM_FWD],
    input  logic                      stall,
    input  logic                      flush,
    output logic                      taken,
    output decode_pkg::word_t         target,
    output logic                      mispredict
);

    logic                      item_valid;
    logic                      item_ready;
    decode_pkg::fetch_bundle_t item;
    decode_pkg::ctrl_t         ctrl;
    decode_pkg::branch_t       br;
    decode_pkg::word_t         rs_value;
    decode_pkg::word_t         rt_value;

    fetch_latch latch_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_bundle  (in_bundle),
        .item_ready (item_ready),
        .item_valid (item_valid),
        .item       (item)
    );

    inst_decoder decoder_i (
        .item (item),
        .ctrl (ctrl)
    );

    branch_resolver #(
        .NUM_FWD (NUM_FWD)
    ) resolver_i (
        .clk        (clk),
        .item_valid (item_valid),
        .item       (item),
        .stall      (stall),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .fwd        (fwd),
        .rf_raddr1  (rf_raddr1),
        .rf_raddr2  (rf_raddr2),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .br         (br)
    );

    issue_merge merge_i (
        .clk        (clk),
        .item_valid (item_valid),
        .item       (item),
        .ctrl       (ctrl),
        .br         (br),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .stall      (stall),
        .flush      (flush),
        .out_ready  (out_ready),
        .item_ready (item_ready),
        .out_valid  (out_valid),
        .out_bundle (out_bundle)
    );

    // redirect address for fetch on a mispredict
    assign taken      = br.taken;
    assign target     = br.real_target;
    assign mispredict = br.mispredict;

endmodule

/* hdl/issue_merge.sv */
`timescale 1ns/1ps

module issue_merge (
    input  logic                      clk,
    input  logic                      item_valid,
    input  decode_pkg::fetch_bundle_t item,
    input  decode_pkg::ctrl_t         ctrl,
    input  decode_pkg::branch_t       br,
    input  decode_pkg::word_t         rs_value,
    input  decode_pkg::word_t         rt_value,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      out_ready,
    output logic                      item_ready,
    output logic                      out_valid,
    output decode_pkg::issue_bundle_t out_bundle
);

    // a flushed item still drains on out_ready, just without a transfer
    assign item_ready = !item_valid || (!stall && out_ready);
    assign out_valid  = item_valid && !stall && !flush;

    always_comb begin
        out_bundle.ctrl        = ctrl;
        out_bundle.rs          = item.inst[25:21];
        out_bundle.rt          = item.inst[20:16];
        out_bundle.rs_value    = rs_value;
        out_bundle.rt_value    = rt_value;
        out_bundle.pc          = item.pc;
        out_bundle.real_target = br.real_target;
        out_bundle.pred_pc     = item.pred_pc;
    end

    // an issue that waits keeps the same item in the latch
    held_item_stays: assert property (
        @(posedge clk) out_valid && !out_ready |=> item_valid && $stable(item)
    );

endmodule

/* hdl/branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver #(
    parameter int NUM_FWD = 3
) (
    input  logic                      clk,
    input  logic                      item_valid,
    input  decode_pkg::fetch_bundle_t item,
    input  logic                      stall,
    input  decode_pkg::word_t         rf_rdata1,
    input  decode_pkg::word_t         rf_rdata2,
    input  decode_pkg::fwd_src_t      fwd [NUM_FWD],
    output decode_pkg::reg_addr_t     rf_raddr1,
    output decode_pkg::reg_addr_t     rf_raddr2,
    output decode_pkg::word_t         rs_value,
    output decode_pkg::word_t         rt_value,
    output decode_pkg::branch_t       br
);

    decode_pkg::opcode_t   op;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;
    decode_pkg::word_t     pc4;
    decode_pkg::word_t     br_offset;
    decode_pkg::word_t     jump_target;

    logic is_beq, is_bne, is_bgez, is_bltz, is_blez, is_bgtz;
    logic is_j, is_jal, is_jr;
    logic rs_eq_rt, rs_lt_zero, rs_le_zero;
    logic cond_taken;

    assign op = item.inst[31:26];
    assign rs = item.inst[25:21];
    assign rt = item.inst[20:16];

    assign rf_raddr1 = rs;
    assign rf_raddr2 = rt;

    always_comb begin
        rs_value = rf_rdata1;
        rt_value = rf_rdata2;
        // walk from the far end so the lowest index wins
        for (int i = NUM_FWD - 1; i >= 0; i--) begin
            if (fwd[i].valid && fwd[i].reg_write && fwd[i].rd != '0) begin
                if (fwd[i].rd == rs) rs_value = fwd[i].result;
                if (fwd[i].rd == rt) rt_value = fwd[i].result;
            end
        end
    end

    assign is_beq  = (op == decode_pkg::OP_BEQ);
    assign is_bne  = (op == decode_pkg::OP_BNE);
    assign is_bgez = (op == decode_pkg::OP_REGIMM) && rt == decode_pkg::RT_BGEZ;
    assign is_bltz = (op == decode_pkg::OP_REGIMM) && rt == decode_pkg::RT_BLTZ;
    assign is_blez = (op == decode_pkg::OP_BLEZ) && rt == '0;
    assign is_bgtz = (op == decode_pkg::OP_BGTZ) && rt == '0;
    assign is_j    = (op == decode_pkg::OP_J);
    assign is_jal  = (op == decode_pkg::OP_JAL);
    assign is_jr   = (op == decode_pkg::OP_SPECIAL) && item.inst[5:0] == decode_pkg::FN_JR
                     && item.inst[20:6] == '0;

    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_lt_zero = rs_value[31];
    assign rs_le_zero = rs_value[31] || rs_value == '0;

    assign pc4       = item.pc + 32'd4;
    assign br_offset = {{14{item.inst[15]}}, item.inst[15:0], 2'b00};

    always_comb begin
        if (is_jr) begin
            jump_target = rs_value;
        end else if (is_j || is_jal) begin
            jump_target = {pc4[31:28], item.inst[25:0], 2'b00};
        end else begin
            jump_target = pc4 + br_offset;
        end
    end

    assign cond_taken = (is_beq  &&  rs_eq_rt)   || (is_bne  && !rs_eq_rt)
                     || (is_bgez && !rs_lt_zero) || (is_bltz &&  rs_lt_zero)
                     || (is_blez &&  rs_le_zero) || (is_bgtz && !rs_le_zero)
                     || is_j || is_jal || is_jr;

    always_comb begin
        br.is_branch   = is_beq | is_bne | is_bgez | is_bltz | is_blez | is_bgtz
                       | is_j | is_jal | is_jr;
        br.taken       = cond_taken && item_valid && !stall;
        br.target      = jump_target;
        // fall-through skips the delay slot
        br.real_target = cond_taken ? jump_target : item.pc + 32'd8;
        br.mispredict  = item_valid && !stall && item.pred_valid
                         && br.real_target != item.pred_pc;
    end

    // redirects go out unstalled and to a word address
    taken_aligned_unstalled: assert property (
        @(posedge clk) br.taken |-> !stall && br.real_target[1:0] == 2'b00
    );

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::fetch_bundle_t item,
    output decode_pkg::ctrl_t         ctrl
);

    decode_pkg::opcode_t   op;
    decode_pkg::reg_addr_t rs;
    decode_pkg::reg_addr_t rt;
    decode_pkg::reg_addr_t rd;
    decode_pkg::reg_addr_t sa;
    decode_pkg::func_t     func;

    logic is_special;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu;
    logic inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_bgez, inst_bltz, inst_blez, inst_bgtz;
    logic inst_j, inst_jal;
    logic any_branch;
    logic dst_is_rt;
    logic known;

    assign op   = item.inst[31:26];
    assign rs   = item.inst[25:21];
    assign rt   = item.inst[20:16];
    assign rd   = item.inst[15:11];
    assign sa   = item.inst[10:6];
    assign func = item.inst[5:0];

    assign is_special = (op == decode_pkg::OP_SPECIAL);

    // three-register forms need a zero shift amount
    assign inst_addu = is_special && func == decode_pkg::FN_ADDU && sa == '0;
    assign inst_subu = is_special && func == decode_pkg::FN_SUBU && sa == '0;
    assign inst_slt  = is_special && func == decode_pkg::FN_SLT  && sa == '0;
    assign inst_sltu = is_special && func == decode_pkg::FN_SLTU && sa == '0;
    assign inst_and  = is_special && func == decode_pkg::FN_AND  && sa == '0;
    assign inst_or   = is_special && func == decode_pkg::FN_OR   && sa == '0;
    assign inst_xor  = is_special && func == decode_pkg::FN_XOR  && sa == '0;
    assign inst_nor  = is_special && func == decode_pkg::FN_NOR  && sa == '0;

    // shifts by immediate, rs unused
    assign inst_sll = is_special && func == decode_pkg::FN_SLL && rs == '0;
    assign inst_srl = is_special && func == decode_pkg::FN_SRL && rs == '0;
    assign inst_sra = is_special && func == decode_pkg::FN_SRA && rs == '0;

    assign inst_jr = is_special && func == decode_pkg::FN_JR
                     && rt == '0 && rd == '0 && sa == '0;

    assign inst_addiu = (op == decode_pkg::OP_ADDIU);
    assign inst_slti  = (op == decode_pkg::OP_SLTI);
    assign inst_sltiu = (op == decode_pkg::OP_SLTIU);
    assign inst_andi  = (op == decode_pkg::OP_ANDI);
    assign inst_ori   = (op == decode_pkg::OP_ORI);
    assign inst_xori  = (op == decode_pkg::OP_XORI);
    assign inst_lui   = (op == decode_pkg::OP_LUI) && rs == '0;
    assign inst_lw    = (op == decode_pkg::OP_LW);
    assign inst_sw    = (op == decode_pkg::OP_SW);

    assign inst_beq  = (op == decode_pkg::OP_BEQ);
    assign inst_bne  = (op == decode_pkg::OP_BNE);
    assign inst_bgez = (op == decode_pkg::OP_REGIMM) && rt == decode_pkg::RT_BGEZ;
    assign inst_bltz = (op == decode_pkg::OP_REGIMM) && rt == decode_pkg::RT_BLTZ;
    assign inst_blez = (op == decode_pkg::OP_BLEZ) && rt == '0;
    assign inst_bgtz = (op == decode_pkg::OP_BGTZ) && rt == '0;
    assign inst_j    = (op == decode_pkg::OP_J);
    assign inst_jal  = (op == decode_pkg::OP_JAL);

    assign any_branch = inst_beq | inst_bne | inst_bgez | inst_bltz | inst_blez | inst_bgtz;

    assign dst_is_rt = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori
                     | inst_xori | inst_lui | inst_lw;

    assign known = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                 | inst_xor | inst_nor | inst_sll | inst_srl | inst_sra | inst_jr
                 | dst_is_rt | inst_sw | any_branch | inst_j | inst_jal;

    always_comb begin
        // lsb is add, msb is lui
        ctrl.alu_op = {inst_lui,
                       inst_sra,
                       inst_srl,
                       inst_sll,
                       inst_xor  | inst_xori,
                       inst_or   | inst_ori,
                       inst_nor,
                       inst_and  | inst_andi,
                       inst_sltu | inst_sltiu,
                       inst_slt  | inst_slti,
                       inst_subu,
                       inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal};
        ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
        ctrl.src1_is_pc   = inst_jal;
        ctrl.src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
        ctrl.src2_is_zimm = inst_andi | inst_ori | inst_xori;
        ctrl.src2_is_8    = inst_jal;
        ctrl.res_from_mem = inst_lw;
        ctrl.gr_we        = !(inst_sw | any_branch | inst_j | inst_jr);
        ctrl.mem_we       = inst_sw;
        ctrl.imm          = item.inst[15:0];
        ctrl.reserved     = !known;
        if (inst_jal) begin
            ctrl.dest = decode_pkg::LINK_REG;
        end else if (dst_is_rt) begin
            ctrl.dest = rt;
        end else begin
            ctrl.dest = rd;
        end
    end

endmodule

/* hdl/fetch_latch.sv */
`timescale 1ns/1ps

module fetch_latch (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  decode_pkg::fetch_bundle_t in_bundle,
    input  logic                      item_ready,
    output logic                      item_valid,
    output decode_pkg::fetch_bundle_t item
);

    // full latch only takes a new item when the old one leaves
    assign in_ready = !item_valid || item_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            item_valid <= 1'b0;
        end else if (in_ready) begin
            item_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            item <= in_bundle;
        end
    end

    // fetch keeps its offer until it is taken
    in_offer_held: assert property (
        @(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_bundle)
    );

endmodule

/* hdl/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  func_t;

    // one-hot, bit 0 first: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_op_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_SW      = 6'h2b;

    // special function field
    localparam func_t FN_SLL  = 6'h00;
    localparam func_t FN_SRL  = 6'h02;
    localparam func_t FN_SRA  = 6'h03;
    localparam func_t FN_JR   = 6'h08;
    localparam func_t FN_ADDU = 6'h21;
    localparam func_t FN_SUBU = 6'h23;
    localparam func_t FN_AND  = 6'h24;
    localparam func_t FN_OR   = 6'h25;
    localparam func_t FN_XOR  = 6'h26;
    localparam func_t FN_NOR  = 6'h27;
    localparam func_t FN_SLT  = 6'h2a;
    localparam func_t FN_SLTU = 6'h2b;

    // regimm rt field
    localparam reg_addr_t RT_BLTZ = 5'h00;
    localparam reg_addr_t RT_BGEZ = 5'h01;

    localparam reg_addr_t LINK_REG = 5'd31;

    typedef struct packed {
        word_t pc;
        word_t inst;
        word_t pred_pc;
        logic  pred_valid;
    } fetch_bundle_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_zimm;
        logic        src2_is_8;
        logic        res_from_mem;
        logic        gr_we;
        logic        mem_we;
        reg_addr_t   dest;
        logic [15:0] imm;
        logic        reserved;
    } ctrl_t;

    typedef struct packed {
        logic  is_branch;
        logic  taken;
        word_t target;
        word_t real_target;
        logic  mispredict;
    } branch_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
        word_t     real_target;
        word_t     pred_pc;
    } issue_bundle_t;

endpackage
